/* vlog.f */
logic/soc_pkg.sv
logic/wb_decoder.sv
logic/wb_bram.sv
logic/wb_timer.sv
logic/wb_gpio.sv
logic/gpio_sevenseg.sv
logic/soc_top.sv
verification/soc_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SoC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module soc_tb \
	-f vlog.f \
	-o soc_sim

output=$(./obj_dir/soc_sim)
echo "$output"

if echo "$output" | grep -q -x -F "Result: PASSED"; then
	exit 0
fi
exit 1

/* verification/soc_tb.sv */
//--------------------------------------------------
// Directed testbench of the peripheral SoC
// Acts as the Wishbone master, checks RAM, decoder,
// timer, GPIO and display against its own models
//--------------------------------------------------
`timescale 1ns/1ps

module soc_tb;

	localparam int          SCAN_DIV_W = 4;
	localparam int          ACK_LIMIT  = 8;
	localparam int          POLL_LIMIT = 100;
	localparam int          SCAN_LIMIT = 4 * (2 ** SCAN_DIV_W) + 8;
	// Tests take under 1000 cycles, limit leaves wide margin
	localparam int          MAX_CYCLES = 20000;
	localparam logic [31:0] SEED       = 32'hd35d179a;

	localparam logic [31:0] TIMER_BASE = 32'hE002_0000;
	localparam logic [31:0] GPIO_BASE  = 32'hE004_0000;
	localparam logic [31:0] NONE_ADR   = 32'h4000_0000;
	localparam logic [31:0] BIT_EN     = 32'd1 << soc_pkg::TCR_EN;
	localparam logic [31:0] BIT_AR     = 32'd1 << soc_pkg::TCR_AR;
	localparam logic [31:0] BIT_IRQEN  = 32'd1 << soc_pkg::TCR_IRQEN;
	localparam logic [31:0] BIT_MATCH  = 32'd1 << soc_pkg::TCR_MATCH;

	// Hex glyphs, bit 0 is segment a, lit segment is 1
	localparam logic [6:0] GLYPHS [16] = '{
		7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
		7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
	};

	logic              clk_i;
	logic              arst_n_i;
	soc_pkg::wb_req_t  bus_req;
	soc_pkg::wb_rsp_t  bus_rsp;
	logic [3:0]        btn_i;
	logic [7:0]        led_o;
	logic [6:0]        seg_o;
	logic [3:0]        an_o;
	soc_pkg::irq_vec_t irq_o;

	int                cycle_count;
	int                errors;
	int                checks;
	int                tests_run;
	int                tests_failed;
	logic [31:0]       ram_model [1024];

	soc_top #(
		.SCAN_DIV_W (SCAN_DIV_W)
	) UUT (
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.bus_req_i (bus_req),
		.bus_rsp_o (bus_rsp),
		.btn_i     (btn_i),
		.led_o     (led_o),
		.seg_o     (seg_o),
		.an_o      (an_o),
		.irq_o     (irq_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	// Run limit
	always @(posedge clk_i) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, tests did not finish", cycle_count);
			$display("Result: FAILED");
			$finish;
		end
	end

	//--------------------------------------------------
	// Compare tasks
	//--------------------------------------------------
	task automatic check_word(input string name, input logic [soc_pkg::DATA_W-1:0] exp,
			input logic [soc_pkg::DATA_W-1:0] got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s: expected %h, got %h", name, exp, got);
		end
	endtask

	task automatic check_irq(input string name, input soc_pkg::irq_vec_t exp,
			input soc_pkg::irq_vec_t got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s: expected %h, got %h", name, exp, got);
		end
	endtask

	task automatic check_seg(input string name, input logic [6:0] exp, input logic [6:0] got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s: expected %h, got %h", name, exp, got);
		end
	endtask

	function automatic soc_pkg::irq_vec_t irq_of(input logic t1, input logic g, input logic t0);
		soc_pkg::irq_vec_t v;
		v.timer1 = t1;
		v.gpio   = g;
		v.timer0 = t0;
		return v;
	endfunction

	function automatic logic [31:0] timer_adr(input soc_pkg::timer_reg_e r);
		return TIMER_BASE | {27'b0, r, 2'b00};
	endfunction

	function automatic logic [31:0] gpio_adr(input soc_pkg::gpio_reg_e r);
		return GPIO_BASE | {28'b0, r, 2'b00};
	endfunction

	// Byte lanes of a RAM write
	function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] upd,
			input logic [3:0] sel);
		logic [31:0] r;
		r = old;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				r[b*8 +: 8] = upd[b*8 +: 8];
			end
		end
		return r;
	endfunction

	//--------------------------------------------------
	// Bus master, called and returning 1 ns after an edge
	//--------------------------------------------------
	task automatic bus_access(input logic [31:0] adr, input logic [31:0] wdat,
			input logic [3:0] sel, input logic we, output logic [31:0] rdat);
		int waited;
		waited     = 0;
		rdat       = '0;
		bus_req    = '0;
		bus_req.adr = adr;
		bus_req.dat = wdat;
		bus_req.sel = sel;
		bus_req.we  = we;
		bus_req.cyc = 1'b1;
		bus_req.stb = 1'b1;
		do begin
			@(posedge clk_i);
			#1;
			waited++;
		end while (!bus_rsp.ack && waited < ACK_LIMIT);
		if (bus_rsp.ack) begin
			rdat = bus_rsp.dat;
		end else begin
			errors++;
			$display("No ack from the bus for address %h", adr);
		end
		bus_req = '0;
	endtask

	task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel);
		logic [31:0] unused;
		bus_access(adr, dat, sel, 1'b1, unused);
	endtask

	task automatic bus_read(input logic [31:0] adr, output logic [31:0] dat);
		bus_access(adr, 32'h0, 4'hF, 1'b0, dat);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_i);
		#1;
	endtask

	task automatic report_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start) begin
			$display("Test %s: ok", name);
		end else begin
			tests_failed++;
			$display("Test %s: %0d errors", name, errors - err_start);
		end
	endtask

	//--------------------------------------------------
	// Directed tests
	//--------------------------------------------------
	task automatic test_ram();
		int          err_start;
		logic [9:0]  idx;
		logic [9:0]  used [$];
		logic [31:0] dat;
		logic [3:0]  sel;
		err_start = errors;
		// Full words to random places
		for (int i = 0; i < 16; i++) begin
			idx = 10'($urandom);
			dat = $urandom;
			bus_write({20'b0, idx, 2'b00}, dat, 4'hF);
			ram_model[idx] = dat;
			used.push_back(idx);
		end
		// Partial lanes over those words
		for (int i = 0; i < 12; i++) begin
			idx = used[$urandom_range(15, 0)];
			sel = 4'($urandom_range(14, 1));
			dat = $urandom;
			bus_write({20'b0, idx, 2'b00}, dat, sel);
			ram_model[idx] = merge_lanes(ram_model[idx], dat, sel);
		end
		foreach (used[i]) begin
			bus_read({20'b0, used[i], 2'b00}, dat);
			check_word($sformatf("ram[%0d]", used[i]), ram_model[used[i]], dat);
		end
		report_test("ram", err_start);
	endtask

	task automatic test_unmapped();
		int          err_start;
		logic [31:0] dat;
		err_start = errors;
		// Word 0 shares low address bits with the unmapped access
		bus_write(32'h0, 32'h1234_5678, 4'hF);
		ram_model[0] = 32'h1234_5678;
		bus_write(NONE_ADR, 32'hDEAD_BEEF, 4'hF);
		bus_read(NONE_ADR, dat);
		check_word("unmapped read", 32'h0, dat);
		bus_read(32'h0, dat);
		check_word("ram[0]", ram_model[0], dat);
		report_test("unmapped", err_start);
	endtask

	task automatic test_timer_oneshot();
		int          err_start;
		int          polls;
		logic [31:0] rd;
		err_start = errors;
		bus_write(timer_adr(soc_pkg::TMR_COMPARE0), 32'd50, 4'hF);
		bus_write(timer_adr(soc_pkg::TMR_COUNTER0), 32'd0, 4'hF);
		bus_write(timer_adr(soc_pkg::TMR_TCR0), BIT_EN | BIT_IRQEN, 4'hF);
		polls = 0;
		rd    = '0;
		while (!rd[soc_pkg::TCR_MATCH] && polls < POLL_LIMIT) begin
			bus_read(timer_adr(soc_pkg::TMR_TCR0), rd);
			polls++;
		end
		if (!rd[soc_pkg::TCR_MATCH]) begin
			errors++;
			$display("Timer 0 never reported a match");
		end else begin
			// Stopped with EN clear, MATCH and IRQEN set
			check_word("TCR0", BIT_MATCH | BIT_IRQEN, rd);
			bus_read(timer_adr(soc_pkg::TMR_COUNTER0), rd);
			check_word("COUNTER0", 32'd50, rd);
			check_irq("irq_o", irq_of(1'b0, 1'b0, 1'b1), irq_o);
		end
		bus_write(timer_adr(soc_pkg::TMR_TCR0), BIT_MATCH | BIT_IRQEN, 4'hF);
		check_irq("irq_o", irq_of(1'b0, 1'b0, 1'b0), irq_o);
		bus_read(timer_adr(soc_pkg::TMR_TCR0), rd);
		check_word("TCR0", BIT_IRQEN, rd);
		report_test("timer_oneshot", err_start);
	endtask

	task automatic test_timer_reload();
		int          err_start;
		int          polls;
		logic [31:0] rd;
		logic [31:0] cnt;
		err_start = errors;
		bus_write(timer_adr(soc_pkg::TMR_COMPARE1), 32'd20, 4'hF);
		bus_write(timer_adr(soc_pkg::TMR_COUNTER1), 32'd0, 4'hF);
		bus_write(timer_adr(soc_pkg::TMR_TCR1), BIT_EN | BIT_AR, 4'hF);
		polls = 0;
		rd    = '0;
		// Keep polling past the match to see reloads
		while (polls < 40) begin
			bus_read(timer_adr(soc_pkg::TMR_TCR1), rd);
			bus_read(timer_adr(soc_pkg::TMR_COUNTER1), cnt);
			check_irq("irq_o", irq_of(1'b0, 1'b0, 1'b0), irq_o);
			if (cnt > 32'd20) begin
				errors++;
				$display("FAIL COUNTER1: %h above COMPARE1 %h", cnt, 32'd20);
			end
			polls++;
		end
		check_word("TCR1", BIT_MATCH | BIT_AR | BIT_EN, rd);
		bus_write(timer_adr(soc_pkg::TMR_TCR1), BIT_MATCH, 4'hF);
		report_test("timer_reload", err_start);
	endtask

	task automatic test_gpio_out();
		int          err_start;
		int          waited;
		logic [31:0] val;
		logic [31:0] rd;
		logic [3:0]  exp_an;
		err_start = errors;
		for (int i = 0; i < 4; i++) begin
			val = $urandom;
			bus_write(gpio_adr(soc_pkg::GPIO_OUT), val, 4'hF);
			check_word("led_o", {24'b0, val[7:0]}, {24'b0, led_o});
			bus_read(gpio_adr(soc_pkg::GPIO_OUT), rd);
			check_word("GPIO_OUT", val, rd);
			// Wait for each digit in turn
			for (int d = 0; d < 4; d++) begin
				exp_an = ~(4'b0001 << d);
				waited = 0;
				while (an_o !== exp_an && waited < SCAN_LIMIT) begin
					wait_cycles(1);
					waited++;
				end
				if (an_o === exp_an) begin
					check_seg($sformatf("seg_o digit %0d", d), ~GLYPHS[val[d*4 +: 4]], seg_o);
				end else begin
					errors++;
					$display("Display never selected digit %0d", d);
				end
			end
		end
		report_test("gpio_out", err_start);
	endtask

	task automatic test_gpio_in();
		int          err_start;
		logic [3:0]  flip;
		logic [31:0] changed;
		logic [31:0] rd;
		err_start = errors;
		for (int i = 0; i < 3; i++) begin
			flip    = 4'($urandom_range(15, 1));
			changed = {20'b0, flip, 8'b0};
			btn_i   = btn_i ^ flip;
			// Synchronizer and change detect
			wait_cycles(6);
			bus_read(gpio_adr(soc_pkg::GPIO_IN), rd);
			check_word("GPIO_IN", {20'b0, btn_i, 8'b0}, rd);
			bus_read(gpio_adr(soc_pkg::GPIO_IRQ_PEND), rd);
			check_word("GPIO_IRQ_PEND", changed, rd);
			// Mask on the other buttons only
			bus_write(gpio_adr(soc_pkg::GPIO_IRQ_MASK), ~changed & 32'h0F00, 4'hF);
			check_irq("irq_o", irq_of(1'b0, 1'b0, 1'b0), irq_o);
			bus_write(gpio_adr(soc_pkg::GPIO_IRQ_MASK), changed, 4'hF);
			check_irq("irq_o", irq_of(1'b0, 1'b1, 1'b0), irq_o);
			bus_write(gpio_adr(soc_pkg::GPIO_IRQ_PEND), changed, 4'hF);
			check_irq("irq_o", irq_of(1'b0, 1'b0, 1'b0), irq_o);
			bus_read(gpio_adr(soc_pkg::GPIO_IRQ_PEND), rd);
			check_word("GPIO_IRQ_PEND", 32'h0, rd);
			bus_write(gpio_adr(soc_pkg::GPIO_IRQ_MASK), 32'h0, 4'hF);
		end
		report_test("gpio_in", err_start);
	endtask

	//--------------------------------------------------
	// Main sequence
	//--------------------------------------------------
	initial begin
		arst_n_i     = 1'b0;
		bus_req      = '0;
		btn_i        = 4'h0;
		cycle_count  = 0;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		void'($urandom(SEED));
		repeat (16) @(posedge clk_i);
		#1;
		arst_n_i = 1'b1;
		wait_cycles(2);
		test_ram();
		test_unmapped();
		test_timer_oneshot();
		test_timer_reload();
		test_gpio_out();
		test_gpio_in();
		$display("Tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* logic/soc_top.sv */
//--------------------------------------------------
// Peripheral side of a small Wishbone SoC
// One bus master port into RAM, timer and GPIO,
// LEDs and seven-segment display off GPIO outputs
//--------------------------------------------------
`timescale 1ns/1ps

module soc_top #(
	parameter int BRAM_ADDR_W = 10,
	parameter int SCAN_DIV_W  = 16
) (
	input  logic              clk_i,
	input  logic              arst_n_i,
	input  soc_pkg::wb_req_t  bus_req_i,
	output soc_pkg::wb_rsp_t  bus_rsp_o,
	input  logic [3:0]        btn_i,
	output logic [7:0]        led_o,
	output logic [6:0]        seg_o,
	output logic [3:0]        an_o,
	output soc_pkg::irq_vec_t irq_o
);

	soc_pkg::wb_req_t bram_req;
	soc_pkg::wb_req_t timer_req;
	soc_pkg::wb_req_t gpio_req;
	soc_pkg::wb_rsp_t bram_rsp;
	soc_pkg::wb_rsp_t timer_rsp;
	soc_pkg::wb_rsp_t gpio_rsp;
	logic [1:0]       timer_irq;
	logic             gpio_irq;
	logic [31:0]      gpio_in;
	logic [31:0]      gpio_out;

	//--------------------------------------------------
	// Bus decoder
	//--------------------------------------------------
	wb_decoder u_decoder (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.mst_req_i   (bus_req_i),
		.mst_rsp_o   (bus_rsp_o),
		.bram_req_o  (bram_req),
		.timer_req_o (timer_req),
		.gpio_req_o  (gpio_req),
		.bram_rsp_i  (bram_rsp),
		.timer_rsp_i (timer_rsp),
		.gpio_rsp_i  (gpio_rsp)
	);

	// RAM at base 0
	wb_bram #(
		.BRAM_ADDR_W (BRAM_ADDR_W)
	) u_bram (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.req_i    (bram_req),
		.rsp_o    (bram_rsp)
	);

	wb_timer u_timer (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.req_i    (timer_req),
		.rsp_o    (timer_rsp),
		.irq_o    (timer_irq)
	);

	// Buttons on inputs 11:8
	assign gpio_in = {20'b0, btn_i, 8'b0};

	wb_gpio u_gpio (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.req_i    (gpio_req),
		.rsp_o    (gpio_rsp),
		.gpio_i   (gpio_in),
		.gpio_o   (gpio_out),
		.irq_o    (gpio_irq)
	);

	// Display shows the low half of OUT
	gpio_sevenseg #(
		.SCAN_DIV_W (SCAN_DIV_W)
	) u_sevenseg (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.value_i  (gpio_out[15:0]),
		.seg_o    (seg_o),
		.an_o     (an_o)
	);

	assign led_o = gpio_out[7:0];

	// Interrupt vector
	assign irq_o.timer1 = timer_irq[1];
	assign irq_o.gpio   = gpio_irq;
	assign irq_o.timer0 = timer_irq[0];

endmodule

/* logic/gpio_sevenseg.sv */
//--------------------------------------------------
// Four-digit multiplexed hex display
// Shows value_i, active-low segments and anodes,
// one digit per 2^SCAN_DIV_W clocks
//--------------------------------------------------
`timescale 1ns/1ps

module gpio_sevenseg #(
	parameter int SCAN_DIV_W = 16
) (
	input  logic        clk_i,
	input  logic        arst_n_i,
	input  logic [15:0] value_i,
	output logic [6:0]  seg_o,
	output logic [3:0]  an_o
);

	logic [SCAN_DIV_W-1:0] div_q;
	logic [1:0]            digit_q;
	logic [3:0]            nibble;
	logic [6:0]            glyph;

	// Refresh divider and digit index
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			div_q   <= '0;
			digit_q <= '0;
		end else begin
			div_q <= div_q + 1'b1;
			if (&div_q) begin
				digit_q <= digit_q + 1'b1;
			end
		end
	end

	assign nibble = value_i[digit_q*4 +: 4];

	// Segments g..a, active high here
	always_comb begin
		case (nibble)
			4'h0: glyph = 7'h3F;
			4'h1: glyph = 7'h06;
			4'h2: glyph = 7'h5B;
			4'h3: glyph = 7'h4F;
			4'h4: glyph = 7'h66;
			4'h5: glyph = 7'h6D;
			4'h6: glyph = 7'h7D;
			4'h7: glyph = 7'h07;
			4'h8: glyph = 7'h7F;
			4'h9: glyph = 7'h6F;
			4'hA: glyph = 7'h77;
			4'hB: glyph = 7'h7C;
			4'hC: glyph = 7'h39;
			4'hD: glyph = 7'h5E;
			4'hE: glyph = 7'h79;
			default: glyph = 7'h71;
		endcase
	end

	assign seg_o = ~glyph;
	assign an_o  = ~(4'b0001 << digit_q);

	// Exactly one digit lit, stepping on divider wrap
	a_one_digit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		$onehot(~an_o));
	a_digit_step: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(&div_q) |=> an_o == {$past(an_o[2:0]), $past(an_o[3])});

endmodule

/* logic/wb_gpio.sv */
//--------------------------------------------------
// Wishbone GPIO with 32 inputs and 32 outputs
// Input changes latch into IRQ_PEND, irq_o when
// a pending bit is unmasked
//--------------------------------------------------
`timescale 1ns/1ps

module wb_gpio (
	input  logic             clk_i,
	input  logic             arst_n_i,
	input  soc_pkg::wb_req_t req_i,
	output soc_pkg::wb_rsp_t rsp_o,
	input  logic [31:0]      gpio_i,
	output logic [31:0]      gpio_o,
	output logic             irq_o
);

	localparam int BYTE_W = soc_pkg::DATA_W / soc_pkg::SEL_W;

	soc_pkg::gpio_reg_e         reg_off;
	logic                       access;
	logic                       wr;
	logic                       ack_q;
	logic [soc_pkg::DATA_W-1:0] dat_q;
	logic [soc_pkg::DATA_W-1:0] rd_dat;
	logic [soc_pkg::DATA_W-1:0] wr_mask;
	logic [31:0]                meta_q;
	logic [31:0]                sync_q;
	logic [31:0]                in_q;
	logic [31:0]                out_q;
	logic [31:0]                mask_q;
	logic [31:0]                pend_q;
	logic [31:0]                pend_clr;

	assign reg_off = soc_pkg::gpio_reg_e'(req_i.adr[3:2]);
	assign access  = req_i.cyc && req_i.stb && !ack_q;
	assign wr      = access && req_i.we;

	// Byte lanes of a write
	always_comb begin
		for (int b = 0; b < soc_pkg::SEL_W; b++) begin
			wr_mask[b*BYTE_W +: BYTE_W] = {BYTE_W{req_i.sel[b]}};
		end
	end

	// Write 1 to clear pending bits
	assign pend_clr = (wr && reg_off == soc_pkg::GPIO_IRQ_PEND) ? (req_i.dat & wr_mask) : '0;

	//--------------------------------------------------
	// Registers
	//--------------------------------------------------
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			meta_q <= '0;
			sync_q <= '0;
			in_q   <= '0;
			out_q  <= '0;
			mask_q <= '0;
			pend_q <= '0;
		end else begin
			// Two-stage synchronizer, then IN
			meta_q <= gpio_i;
			sync_q <= meta_q;
			in_q   <= sync_q;
			// Change detect has priority over clear
			pend_q <= (pend_q & ~pend_clr) | (in_q ^ sync_q);
			if (wr && reg_off == soc_pkg::GPIO_OUT) begin
				out_q <= (out_q & ~wr_mask) | (req_i.dat & wr_mask);
			end
			if (wr && reg_off == soc_pkg::GPIO_IRQ_MASK) begin
				mask_q <= (mask_q & ~wr_mask) | (req_i.dat & wr_mask);
			end
		end
	end

	always_comb begin
		case (reg_off)
			soc_pkg::GPIO_IN:       rd_dat = in_q;
			soc_pkg::GPIO_OUT:      rd_dat = out_q;
			soc_pkg::GPIO_IRQ_MASK: rd_dat = mask_q;
			default:                rd_dat = pend_q;
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	always_ff @(posedge clk_i) begin
		if (access) begin
			dat_q <= rd_dat;
		end
	end

	assign rsp_o.dat = dat_q;
	assign rsp_o.ack = ack_q;
	assign gpio_o    = out_q;
	assign irq_o     = |(pend_q & mask_q);

endmodule

/* logic/wb_timer.sv */
//--------------------------------------------------
// Two-channel Wishbone timer
// Per channel TCR, COMPARE and COUNTER words
// irq_o[n] is MATCH and IRQEN of channel n
//--------------------------------------------------
`timescale 1ns/1ps

module wb_timer (
	input  logic             clk_i,
	input  logic             arst_n_i,
	input  soc_pkg::wb_req_t req_i,
	output soc_pkg::wb_rsp_t rsp_o,
	output logic [1:0]       irq_o
);

	soc_pkg::timer_reg_e        reg_off;
	logic                       access;
	logic                       wr;
	logic                       ack_q;
	logic [soc_pkg::DATA_W-1:0] dat_q;
	logic [soc_pkg::DATA_W-1:0] rd_dat;
	logic [soc_pkg::DATA_W-1:0] rd_tcr [2];
	logic [soc_pkg::DATA_W-1:0] rd_cmp [2];
	logic [soc_pkg::DATA_W-1:0] rd_cnt [2];

	assign reg_off = soc_pkg::timer_reg_e'(req_i.adr[4:2]);
	assign access  = req_i.cyc && req_i.stb && !ack_q;
	assign wr      = access && req_i.we;

	//--------------------------------------------------
	// Channels
	//--------------------------------------------------
	for (genvar ch = 0; ch < 2; ch++) begin : g_chan
		localparam soc_pkg::timer_reg_e OFF_TCR =
			(ch == 0) ? soc_pkg::TMR_TCR0 : soc_pkg::TMR_TCR1;
		localparam soc_pkg::timer_reg_e OFF_CMP =
			(ch == 0) ? soc_pkg::TMR_COMPARE0 : soc_pkg::TMR_COMPARE1;
		localparam soc_pkg::timer_reg_e OFF_CNT =
			(ch == 0) ? soc_pkg::TMR_COUNTER0 : soc_pkg::TMR_COUNTER1;

		logic [3:0]                 tcr;
		logic [soc_pkg::DATA_W-1:0] cmp;
		logic [soc_pkg::DATA_W-1:0] cnt;
		logic                       hit;

		assign hit = (cnt == cmp);

		always_ff @(posedge clk_i or negedge arst_n_i) begin
			if (!arst_n_i) begin
				tcr <= '0;
				cmp <= '0;
				cnt <= '0;
			end else begin
				// Count while enabled
				if (tcr[soc_pkg::TCR_EN] && !(wr && reg_off == OFF_CNT)) begin
					if (hit) begin
						// Reload, or stop and hold the count
						if (tcr[soc_pkg::TCR_AR]) begin
							cnt <= '0;
						end else begin
							tcr[soc_pkg::TCR_EN] <= 1'b0;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				if (wr && reg_off == OFF_CNT) begin
					cnt <= req_i.dat;
				end
				if (wr && reg_off == OFF_CMP) begin
					cmp <= req_i.dat;
				end
				// Bus write wins over the stop on match
				if (wr && reg_off == OFF_TCR) begin
					tcr[soc_pkg::TCR_EN]    <= req_i.dat[soc_pkg::TCR_EN];
					tcr[soc_pkg::TCR_AR]    <= req_i.dat[soc_pkg::TCR_AR];
					tcr[soc_pkg::TCR_IRQEN] <= req_i.dat[soc_pkg::TCR_IRQEN];
					if (req_i.dat[soc_pkg::TCR_MATCH]) begin
						tcr[soc_pkg::TCR_MATCH] <= 1'b0;
					end
				end
				// A new match is never lost to a clear
				if (tcr[soc_pkg::TCR_EN] && hit) begin
					tcr[soc_pkg::TCR_MATCH] <= 1'b1;
				end
			end
		end

		assign irq_o[ch]  = tcr[soc_pkg::TCR_MATCH] & tcr[soc_pkg::TCR_IRQEN];
		assign rd_tcr[ch] = {{(soc_pkg::DATA_W-4){1'b0}}, tcr};
		assign rd_cmp[ch] = cmp;
		assign rd_cnt[ch] = cnt;

		// Interrupt only follows a match of a running channel
		a_irq_match: assert property (@(posedge clk_i) disable iff (!arst_n_i)
			irq_o[ch] |-> tcr[soc_pkg::TCR_MATCH] &&
				$past(tcr[soc_pkg::TCR_EN] || tcr[soc_pkg::TCR_MATCH]));
	end

	//--------------------------------------------------
	// Bus read side
	//--------------------------------------------------
	always_comb begin
		case (reg_off)
			soc_pkg::TMR_TCR0:     rd_dat = rd_tcr[0];
			soc_pkg::TMR_COMPARE0: rd_dat = rd_cmp[0];
			soc_pkg::TMR_COUNTER0: rd_dat = rd_cnt[0];
			soc_pkg::TMR_TCR1:     rd_dat = rd_tcr[1];
			soc_pkg::TMR_COMPARE1: rd_dat = rd_cmp[1];
			soc_pkg::TMR_COUNTER1: rd_dat = rd_cnt[1];
			default:               rd_dat = '0;
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	always_ff @(posedge clk_i) begin
		if (access) begin
			dat_q <= rd_dat;
		end
	end

	assign rsp_o.dat = dat_q;
	assign rsp_o.ack = ack_q;

endmodule

/* logic/wb_bram.sv */
//--------------------------------------------------
// Wishbone block RAM, one word per access
// Byte-lane writes by sel, ack one cycle after stb
//--------------------------------------------------
`timescale 1ns/1ps

module wb_bram #(
	parameter int BRAM_ADDR_W = 10
) (
	input  logic             clk_i,
	input  logic             arst_n_i,
	input  soc_pkg::wb_req_t req_i,
	output soc_pkg::wb_rsp_t rsp_o
);

	localparam int WORDS  = 2 ** BRAM_ADDR_W;
	localparam int BYTE_W = soc_pkg::DATA_W / soc_pkg::SEL_W;

	logic [soc_pkg::DATA_W-1:0] mem [WORDS];
	logic [soc_pkg::DATA_W-1:0] dat_q;
	logic [BRAM_ADDR_W-1:0]     word_adr;
	logic                       access;
	logic                       ack_q;

	// Word index, upper address bits wrap
	assign word_adr = req_i.adr[BRAM_ADDR_W+1:2];

	// First cycle of a strobed cycle
	assign access = req_i.cyc && req_i.stb && !ack_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	// Storage and read port
	always_ff @(posedge clk_i) begin
		if (access) begin
			// Old word is returned on a write
			dat_q <= mem[word_adr];
			if (req_i.we) begin
				for (int b = 0; b < soc_pkg::SEL_W; b++) begin
					if (req_i.sel[b]) begin
						mem[word_adr][b*BYTE_W +: BYTE_W] <= req_i.dat[b*BYTE_W +: BYTE_W];
					end
				end
			end
		end
	end

	assign rsp_o.dat = dat_q;
	assign rsp_o.ack = ack_q;

endmodule

/* logic/wb_decoder.sv */
//--------------------------------------------------
// Wishbone address decoder for one master
// Strobes the slave picked by the region field,
// returns its response, acks unmapped accesses
//--------------------------------------------------
`timescale 1ns/1ps

module wb_decoder (
	input  logic             clk_i,
	input  logic             arst_n_i,
	input  soc_pkg::wb_req_t mst_req_i,
	output soc_pkg::wb_rsp_t mst_rsp_o,
	output soc_pkg::wb_req_t bram_req_o,
	output soc_pkg::wb_req_t timer_req_o,
	output soc_pkg::wb_req_t gpio_req_o,
	input  soc_pkg::wb_rsp_t bram_rsp_i,
	input  soc_pkg::wb_rsp_t timer_rsp_i,
	input  soc_pkg::wb_rsp_t gpio_rsp_i
);

	logic [soc_pkg::REGION_W-1:0] region;
	soc_pkg::slave_e              slv;
	logic                         none_ack;
	logic [2:0]                   slv_ack;
	logic [2:0]                   slv_stb;

	// Region field of the address
	assign region = mst_req_i.adr[soc_pkg::ADDR_W-1:soc_pkg::REGION_LSB];

	always_comb begin
		case (region)
			soc_pkg::REGION_BRAM:  slv = soc_pkg::SLV_BRAM;
			soc_pkg::REGION_TIMER: slv = soc_pkg::SLV_TIMER;
			soc_pkg::REGION_GPIO:  slv = soc_pkg::SLV_GPIO;
			default:               slv = soc_pkg::SLV_NONE;
		endcase
	end

	// Same request to all, strobe only to the target
	always_comb begin
		bram_req_o      = mst_req_i;
		timer_req_o     = mst_req_i;
		gpio_req_o      = mst_req_i;
		bram_req_o.stb  = mst_req_i.stb && (slv == soc_pkg::SLV_BRAM);
		timer_req_o.stb = mst_req_i.stb && (slv == soc_pkg::SLV_TIMER);
		gpio_req_o.stb  = mst_req_i.stb && (slv == soc_pkg::SLV_GPIO);
	end

	// Unmapped access, one-cycle ack, writes dropped
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			none_ack <= 1'b0;
		end else begin
			none_ack <= mst_req_i.cyc && mst_req_i.stb &&
				(slv == soc_pkg::SLV_NONE) && !none_ack;
		end
	end

	// Response of the selected slave
	always_comb begin
		case (slv)
			soc_pkg::SLV_BRAM:  mst_rsp_o = bram_rsp_i;
			soc_pkg::SLV_TIMER: mst_rsp_o = timer_rsp_i;
			soc_pkg::SLV_GPIO:  mst_rsp_o = gpio_rsp_i;
			default: begin
				mst_rsp_o.dat = '0;
				mst_rsp_o.ack = none_ack;
			end
		endcase
	end

	//--------------------------------------------------
	// Checks
	//--------------------------------------------------
	assign slv_ack = {gpio_rsp_i.ack, timer_rsp_i.ack, bram_rsp_i.ack};
	assign slv_stb = {gpio_req_o.stb, timer_req_o.stb, bram_req_o.stb};

	// Never two responders at once
	a_single_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		$onehot0({slv_ack, none_ack}));

	// A slave only acks after being strobed
	a_ack_strobed: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(slv_ack & ~$past(slv_stb)) == 3'b000);

endmodule

/* logic/soc_pkg.sv */
//--------------------------------------------------
// Shared definitions of the peripheral SoC
// Bus widths, Wishbone request/response structs,
// interrupt vector, register offsets, address map
//--------------------------------------------------
package soc_pkg;

	//--------------------------------------------------
	// Bus widths
	//--------------------------------------------------
	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;
	localparam int SEL_W  = 4;

	// Master to slave
	typedef struct packed {
		logic [ADDR_W-1:0] adr;
		logic [DATA_W-1:0] dat;
		logic [SEL_W-1:0]  sel;
		logic              we;
		logic              cyc;
		logic              stb;
	} wb_req_t;

	// Slave to master
	typedef struct packed {
		logic [DATA_W-1:0] dat;
		logic              ack;
	} wb_rsp_t;

	// Interrupt lines, all active high
	typedef struct packed {
		logic timer1;
		logic gpio;
		logic timer0;
	} irq_vec_t;

	// Decoder targets
	typedef enum logic [1:0] {
		SLV_BRAM,
		SLV_TIMER,
		SLV_GPIO,
		SLV_NONE
	} slave_e;

	// Timer word offsets, bit 2 picks the channel
	typedef enum logic [2:0] {
		TMR_TCR0     = 3'd0,
		TMR_COMPARE0 = 3'd1,
		TMR_COUNTER0 = 3'd2,
		TMR_TCR1     = 3'd4,
		TMR_COMPARE1 = 3'd5,
		TMR_COUNTER1 = 3'd6
	} timer_reg_e;

	// GPIO word offsets
	typedef enum logic [1:0] {
		GPIO_IN       = 2'd0,
		GPIO_OUT      = 2'd1,
		GPIO_IRQ_MASK = 2'd2,
		GPIO_IRQ_PEND = 2'd3
	} gpio_reg_e;

	// Timer control bits
	localparam int TCR_EN    = 0;
	localparam int TCR_AR    = 1;
	localparam int TCR_IRQEN = 2;
	localparam int TCR_MATCH = 3;

	//--------------------------------------------------
	// Address map, region field is adr[31:17]
	//--------------------------------------------------
	localparam int REGION_LSB = 17;
	localparam int REGION_W   = ADDR_W - REGION_LSB;

	localparam logic [REGION_W-1:0] REGION_BRAM  = 15'h0000;
	localparam logic [REGION_W-1:0] REGION_TIMER = 15'h7001;
	localparam logic [REGION_W-1:0] REGION_GPIO  = 15'h7002;

endpackage
